/* common/bp_pkg.sv */
// Shared types for the branch prediction block of the 16-bit CPU front end.
// Holds the 2-bit counter encoding, the table payloads and the structs that
// travel between fetch, the predictor, the IF/ID register and decode.
// Modules take it with a wildcard import in their header.

package bp_pkg;

  ////////////////////////////////////////
  // Sizing defaults
  ////////////////////////////////////////
  parameter int PC_WIDTH_DEF   = 16;  // Width of every PC and target.
  parameter int INDEX_BITS_DEF = 3;   // 8 entries per table.

  ////////////////////////////////////////
  // Counter and payload types
  ////////////////////////////////////////
  // Two bit saturating counter, the MSB is the taken prediction.
  typedef enum logic [1:0] {
    strong_not_taken = 2'd0,  // Never taken so far.
    weak_not_taken   = 2'd1,  // Miss default.
    weak_taken       = 2'd2,  // Leaning taken.
    strong_taken     = 2'd3   // Saturated taken.
  } bp_state_t;

  typedef logic [PC_WIDTH_DEF-1:0] bp_target_t;  // BTB payload.

  ////////////////////////////////////////
  // Port structs
  ////////////////////////////////////////
  // Request from the fetch stage.
  typedef struct packed {
    logic [PC_WIDTH_DEF-1:0] pc;     // Current fetch PC.
    logic                    valid;  // Fetch slot holds an instruction.
  } bp_fetch_t;

  // Result of one lookup, same cycle as the PC.
  typedef struct packed {
    bp_state_t  state;   // Counter, or weak_not_taken on a miss.
    logic       taken;   // MSB of state.
    bp_target_t target;  // Raw BTB payload at the index.
  } bp_predict_t;

  // Payload of the IF/ID pipeline register.
  typedef struct packed {
    logic                    valid;  // Slot carries an instruction.
    logic [PC_WIDTH_DEF-1:0] pc;     // PC fetched one cycle earlier.
    bp_predict_t             pred;   // Prediction made for that PC.
  } bp_if_id_t;

  // Branch outcome reported by decode.
  typedef struct packed {
    logic [PC_WIDTH_DEF-1:0] pc;          // IF/ID pc of the branch.
    bp_state_t               prev_state;  // Prediction carried through IF/ID.
    logic                    taken;       // Actual direction.
    bp_target_t              target;      // Actual target.
    logic                    wen_bht;     // Write the counter entry.
    logic                    wen_btb;     // Write the target entry.
  } bp_resolve_t;

endpackage

/* hw/predictor/bp_tag_table.sv */
// Direct-mapped tagged table used for both the BHT and the BTB.
// One asynchronous read port returns hit and payload for the fetch PC,
// a second tag compare reports a hit at the write index for the update policy.
// The payload type is a parameter so one body serves counters and targets.

`timescale 1ns/10ps

module bp_tag_table import bp_pkg::*; #(
  parameter int  INDEX_BITS = INDEX_BITS_DEF,
  parameter type payload_t  = bp_target_t
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [PC_WIDTH_DEF-1:0] rd_pc,    // Lookup PC.
  output logic                    rd_hit,   // Valid entry with matching tag.
  output payload_t                rd_data,  // Payload at the lookup index.
  input  logic [PC_WIDTH_DEF-1:0] wr_pc,    // Update PC.
  output logic                    wr_hit,   // Tag match at the update index.
  input  logic                    wr_en,    // Write the update entry.
  input  payload_t                wr_data   // New payload.
);

  localparam int ENTRIES  = 1 << INDEX_BITS;
  localparam int TAG_BITS = PC_WIDTH_DEF - INDEX_BITS - 1;  // PC bit 0 is the byte lane.

  logic [TAG_BITS-1:0]   tag_q   [ENTRIES];
  logic                  valid_q [ENTRIES];
  payload_t              data_q  [ENTRIES];

  logic [INDEX_BITS-1:0] rd_idx, wr_idx;
  logic [TAG_BITS-1:0]   rd_tag, wr_tag;

  assign rd_idx = rd_pc[INDEX_BITS:1];               // Halfword aligned index.
  assign rd_tag = rd_pc[PC_WIDTH_DEF-1:INDEX_BITS+1];
  assign wr_idx = wr_pc[INDEX_BITS:1];
  assign wr_tag = wr_pc[PC_WIDTH_DEF-1:INDEX_BITS+1];

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////
  assign rd_hit  = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);  // Old contents this cycle.
  assign rd_data = data_q[rd_idx];
  assign wr_hit  = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);  // Feeds the counter policy.

  ////////////////////////////////////////
  // Write side
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ENTRIES; i++) begin
        valid_q[i] <= 1'b0;             // Table starts empty.
        data_q[i]  <= payload_t'('0);   // Targets read back as zero.
      end
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
      data_q[wr_idx]  <= wr_data;
    end
  end

  // Tags are only meaningful behind a set valid bit.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_q[wr_idx] <= wr_tag;
    end
  end

endmodule

/* hw/predictor/bp_counter_update.sv */
// Next-state policy for the 2-bit branch counter.
// Takes the prediction carried through IF/ID, the BHT tag match at the
// write index and the resolved direction, and returns the state to store.

`timescale 1ns/10ps

module bp_counter_update import bp_pkg::*; (
  input  bp_state_t prev_state,  // Prediction carried with the branch.
  input  logic      tag_match,   // Entry at the index belongs to this PC.
  input  logic      taken,       // Resolved direction.
  output bp_state_t next_state   // Value written into the BHT.
);

  ////////////////////////////////////////
  // Saturating counter with alias reset
  ////////////////////////////////////////
  // A mismatching entry restarts the branch at weak_not_taken,
  // except from weak_not_taken which always moves by direction.
  always_comb begin
    next_state = weak_not_taken;  // Safe fallback.
    case (prev_state)
      strong_not_taken: begin
        if (tag_match) begin
          next_state = taken ? weak_not_taken : strong_not_taken;  // Step up or hold.
        end else begin
          next_state = weak_not_taken;  // Foreign entry.
        end
      end
      weak_not_taken: begin
        next_state = taken ? weak_taken : strong_not_taken;  // Match ignored here.
      end
      weak_taken: begin
        if (tag_match) begin
          next_state = taken ? strong_taken : weak_not_taken;
        end else begin
          next_state = weak_not_taken;
        end
      end
      strong_taken: begin
        if (tag_match) begin
          next_state = taken ? strong_taken : weak_taken;  // Saturate or step down.
        end else begin
          next_state = weak_not_taken;
        end
      end
      default: begin
        next_state = weak_not_taken;
      end
    endcase
  end

endmodule

/* hw/predictor/branch_predictor.sv */
// Branch predictor built from a BHT of 2-bit counters and a BTB of targets.
// Lookup is combinational from fetch_pc to predict.
// Decode writes back through resolve, the write lands on the next clock edge
// and is visible to lookups from the following cycle.

`timescale 1ns/10ps

module branch_predictor import bp_pkg::*; #(
  parameter int INDEX_BITS = INDEX_BITS_DEF
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    enable,    // Predictor on.
  input  logic [PC_WIDTH_DEF-1:0] fetch_pc,  // Current fetch PC.
  output bp_predict_t             predict,   // Same cycle prediction.
  input  bp_resolve_t             resolve    // Outcome from decode.
);

  bp_state_t  bht_rd_state;   // Stored counter at the fetch index.
  logic       bht_rd_hit;     // Counter belongs to fetch_pc.
  logic       bht_wr_hit;     // Counter belongs to resolve.pc.
  bp_state_t  bht_next_state; // Policy output.
  bp_target_t btb_rd_target;  // Target at the fetch index.
  logic       bht_wen;
  logic       btb_wen;

  ////////////////////////////////////////
  // Write enables
  ////////////////////////////////////////
  assign bht_wen = enable && resolve.wen_bht;  // Disabled predictor ignores decode.
  assign btb_wen = enable && resolve.wen_btb;

  ////////////////////////////////////////
  // Tables
  ////////////////////////////////////////
  bp_tag_table #(
    .INDEX_BITS (INDEX_BITS),
    .payload_t  (bp_state_t)
  ) bht_table (
    .clk     (clk),
    .rst     (rst),
    .rd_pc   (fetch_pc),
    .rd_hit  (bht_rd_hit),
    .rd_data (bht_rd_state),
    .wr_pc   (resolve.pc),
    .wr_hit  (bht_wr_hit),
    .wr_en   (bht_wen),
    .wr_data (bht_next_state)
  );

  // The BTB is read without its tag, so its hit outputs stay open.
  bp_tag_table #(
    .INDEX_BITS (INDEX_BITS),
    .payload_t  (bp_target_t)
  ) btb_table (
    .clk     (clk),
    .rst     (rst),
    .rd_pc   (fetch_pc),
    .rd_hit  (),
    .rd_data (btb_rd_target),
    .wr_pc   (resolve.pc),
    .wr_hit  (),
    .wr_en   (btb_wen),
    .wr_data (resolve.target)
  );

  ////////////////////////////////////////
  // Counter policy
  ////////////////////////////////////////
  bp_counter_update u_update (
    .prev_state (resolve.prev_state),
    .tag_match  (bht_wr_hit),
    .taken      (resolve.taken),
    .next_state (bht_next_state)
  );

  ////////////////////////////////////////
  // Prediction output
  ////////////////////////////////////////
  always_comb begin
    if (enable && bht_rd_hit) begin
      predict.state = bht_rd_state;      // Trained entry.
    end else begin
      predict.state = weak_not_taken;    // Miss or disabled.
    end
    predict.taken  = predict.state[1];   // MSB means taken.
    predict.target = enable ? btb_rd_target : bp_target_t'('0);
  end

endmodule

/* hw/bp_if_id_reg.sv */
// IF/ID pipeline register carrying the fetch PC and its prediction to decode.
// Stall holds the whole register, flush clears valid and wins over stall.

`timescale 1ns/10ps

module bp_if_id_reg import bp_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        stall,  // Hold the register.
  input  logic        flush,  // Kill the slot.
  input  bp_fetch_t   fetch,  // Fetch request of this cycle.
  input  bp_predict_t pred,   // Lookup result for fetch.pc.
  output bp_if_id_t   if_id   // Registered slot for decode.
);

  logic                    valid_q;
  logic [PC_WIDTH_DEF-1:0] pc_q;
  bp_predict_t             pred_q;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (flush) begin
      valid_q <= 1'b0;         // Flush beats stall.
    end else if (!stall) begin
      valid_q <= fetch.valid;
    end
  end

  ////////////////////////////////////////
  // Payload
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!stall) begin
      pc_q   <= fetch.pc;
      pred_q <= pred;          // Carried to decode as prev_state.
    end
  end

  assign if_id = '{valid: valid_q, pc: pc_q, pred: pred_q};

endmodule

/* hw/bp_top.sv */
// Top level of the branch prediction block.
// Fetch looks up the predictor and the result is registered into IF/ID,
// decode resolves branches back into the tables through resolve.

`timescale 1ns/10ps

module bp_top import bp_pkg::*; #(
  parameter int INDEX_BITS = INDEX_BITS_DEF  // Table has 2**INDEX_BITS entries.
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        enable,   // Predictor on.
  input  bp_fetch_t   fetch,    // From fetch.
  input  logic        stall,    // Hold IF/ID.
  input  logic        flush,    // Clear IF/ID valid.
  input  bp_resolve_t resolve,  // From decode.
  output bp_predict_t predict,  // To fetch.
  output bp_if_id_t   if_id     // To decode.
);

  ////////////////////////////////////////
  // Predictor
  ////////////////////////////////////////
  branch_predictor #(
    .INDEX_BITS (INDEX_BITS)
  ) u_predictor (
    .clk      (clk),
    .rst      (rst),
    .enable   (enable),
    .fetch_pc (fetch.pc),
    .predict  (predict),
    .resolve  (resolve)
  );

  ////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////
  bp_if_id_reg u_if_id (
    .clk   (clk),
    .rst   (rst),
    .stall (stall),
    .flush (flush),
    .fetch (fetch),
    .pred  (predict),   // Same cycle lookup result.
    .if_id (if_id)
  );

endmodule

/* dv/bp_props.sv */
// Concurrent assertions on reset, prediction defaults and flush of bp_top.
// Bound into every bp_top instance by the bind at the end of this file.

`timescale 1ns/10ps

module bp_props import bp_pkg::*; (
  input logic        clk,
  input logic        rst,
  input logic        enable,
  input logic        flush,
  input bp_predict_t predict,
  input bp_if_id_t   if_id
);

  ////////////////////////////////////////
  // IF/ID valid
  ////////////////////////////////////////
  a_reset_clears_valid: assert property (@(posedge clk) rst |=> !if_id.valid)
    else $error("if_id.valid high in the cycle after reset");

  a_flush_clears_valid: assert property (@(posedge clk) flush |=> !if_id.valid)
    else $error("if_id.valid high in the cycle after a flush");

  ////////////////////////////////////////
  // Prediction
  ////////////////////////////////////////
  a_taken_is_msb: assert property (@(posedge clk) disable iff (rst)
    predict.taken == predict.state[1])
    else $error("predict.taken differs from the counter MSB");

  // A disabled predictor always shows the miss default.
  a_disabled_default: assert property (@(posedge clk) disable iff (rst)
    !enable |-> (predict.state == weak_not_taken && predict.target == 16'h0000))
    else $error("prediction not at its default while disabled");

endmodule

bind bp_top bp_props u_props (
  .clk     (clk),
  .rst     (rst),
  .enable  (enable),
  .flush   (flush),
  .predict (predict),
  .if_id   (if_id)
);

/* dv/bp_tb.sv */
// Directed testbench for the branch prediction block.
// A reference model of the BHT, the BTB and the IF/ID register follows the DUT
// edge by edge. Outputs are compared at every falling edge.

`timescale 1ns/10ps

module bp_tb import bp_pkg::*; ();

  localparam int INDEX_BITS  = INDEX_BITS_DEF;
  localparam int ENTRIES     = 1 << INDEX_BITS;
  localparam int TAG_BITS    = PC_WIDTH_DEF - INDEX_BITS - 1;
  localparam int TRAIN_LIMIT = 8;                    // Resolves allowed to reach taken.

  logic        clk;
  logic        rst;
  logic        enable;
  logic        stall;
  logic        flush;
  bp_fetch_t   fetch;
  bp_resolve_t resolve;
  bp_predict_t predict;
  bp_if_id_t   if_id;

  // Reference model of both tables and the IF/ID slot.
  logic                m_bht_valid  [ENTRIES];
  logic [TAG_BITS-1:0] m_bht_tag    [ENTRIES];
  bp_state_t           m_bht_state  [ENTRIES];
  bp_target_t          m_btb_target [ENTRIES];
  bp_if_id_t           exp_if_id;

  int seed;
  int error_count;

  bp_top #(
    .INDEX_BITS (INDEX_BITS)
  ) dut (
    .clk     (clk),
    .rst     (rst),
    .enable  (enable),
    .fetch   (fetch),
    .stall   (stall),
    .flush   (flush),
    .resolve (resolve),
    .predict (predict),
    .if_id   (if_id)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                          // 20 ns period.
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic int index_of(input logic [PC_WIDTH_DEF-1:0] pc);
    return int'(pc >> 1) % ENTRIES;                  // Halfword entries.
  endfunction

  function automatic logic [TAG_BITS-1:0] tag_of(input logic [PC_WIDTH_DEF-1:0] pc);
    logic [PC_WIDTH_DEF-1:0] t;
    t = pc >> (INDEX_BITS + 1);
    return t[TAG_BITS-1:0];
  endfunction

  // Count up or down with saturation, a foreign entry restarts at weak_not_taken.
  function automatic bp_state_t next_counter(input bp_state_t prev, input logic match,
                                             input logic taken);
    logic [1:0] v;
    v = prev;
    if (!match && prev != weak_not_taken) begin
      return weak_not_taken;
    end
    if (taken && v != 2'd3) begin
      v = v + 2'd1;
    end else if (!taken && v != 2'd0) begin
      v = v - 2'd1;
    end
    return bp_state_t'(v);
  endfunction

  function automatic bp_predict_t lookup_ref(input logic [PC_WIDTH_DEF-1:0] pc, input logic en);
    bp_predict_t p;
    int          i;
    i = index_of(pc);
    p.state = weak_not_taken;                        // Miss default.
    if (en && m_bht_valid[i] && m_bht_tag[i] == tag_of(pc)) begin
      p.state = m_bht_state[i];
    end
    p.taken  = (p.state == weak_taken) || (p.state == strong_taken);
    p.target = en ? m_btb_target[i] : 16'h0000;      // No tag check on the BTB.
    return p;
  endfunction

  function automatic bp_predict_t pred_value(input bp_state_t s, input logic t,
                                             input bp_target_t tgt);
    bp_predict_t p;
    p.state  = s;
    p.taken  = t;
    p.target = tgt;
    return p;
  endfunction

  function automatic bp_fetch_t fetch_of(input logic [PC_WIDTH_DEF-1:0] pc, input logic v);
    bp_fetch_t f;
    f.pc    = pc;
    f.valid = v;
    return f;
  endfunction

  function automatic bp_resolve_t resolve_of(input logic [PC_WIDTH_DEF-1:0] pc,
                                             input bp_state_t prev, input logic taken,
                                             input bp_target_t tgt, input logic wen_bht,
                                             input logic wen_btb);
    bp_resolve_t r;
    r.pc         = pc;
    r.prev_state = prev;
    r.taken      = taken;
    r.target     = tgt;
    r.wen_bht    = wen_bht;
    r.wen_btb    = wen_btb;
    return r;
  endfunction

  // Called at the rising edge, reads the inputs the DUT samples there.
  task automatic advance_model();
    bp_predict_t p;
    int          i;
    p = lookup_ref(fetch.pc, enable);                // Old contents this cycle.
    if (!stall) begin
      exp_if_id.pc   = fetch.pc;
      exp_if_id.pred = p;
    end
    if (rst || flush) begin
      exp_if_id.valid = 1'b0;
    end else if (!stall) begin
      exp_if_id.valid = fetch.valid;
    end
    if (rst) begin
      for (i = 0; i < ENTRIES; i++) begin
        m_bht_valid[i]  = 1'b0;
        m_btb_target[i] = 16'h0000;
      end
    end else if (enable) begin
      i = index_of(resolve.pc);
      if (resolve.wen_btb) begin
        m_btb_target[i] = resolve.target;
      end
      if (resolve.wen_bht) begin
        m_bht_state[i] = next_counter(resolve.prev_state,
                                      m_bht_valid[i] && m_bht_tag[i] == tag_of(resolve.pc),
                                      resolve.taken);
        m_bht_valid[i] = 1'b1;
        m_bht_tag[i]   = tag_of(resolve.pc);
      end
    end
  endtask

  ////////////////////////////////////////
  // Checks and error reporting
  ////////////////////////////////////////
  task automatic stop_run();
    $display("TB FAILED");
    $fatal(1, "Stopped at the first error.");
  endtask

  task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
    error_count++;
    stop_run();
  endtask

  task automatic timeout_stop(input string what);
    $display("Timeout: %s", what);
    error_count++;
    stop_run();
  endtask

  task automatic check_predict(input bp_predict_t got, input bp_predict_t exp);
    if (got.state !== exp.state) report_value("predict.state", 32'(got.state), 32'(exp.state));
    if (got.taken !== exp.taken) report_value("predict.taken", 32'(got.taken), 32'(exp.taken));
    if (got.target !== exp.target) report_value("predict.target", 32'(got.target), 32'(exp.target));
  endtask

  task automatic check_if_id(input bp_if_id_t got, input bp_if_id_t exp);
    if (got.valid !== exp.valid) report_value("if_id.valid", 32'(got.valid), 32'(exp.valid));
    if (got.pc !== exp.pc) report_value("if_id.pc", 32'(got.pc), 32'(exp.pc));
    if (got.pred.state !== exp.pred.state) begin
      report_value("if_id.pred.state", 32'(got.pred.state), 32'(exp.pred.state));
    end
    if (got.pred.taken !== exp.pred.taken) begin
      report_value("if_id.pred.taken", 32'(got.pred.taken), 32'(exp.pred.taken));
    end
    if (got.pred.target !== exp.pred.target) begin
      report_value("if_id.pred.target", 32'(got.pred.target), 32'(exp.pred.target));
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  // One clock: update the model, drive new inputs, compare at the falling edge.
  task automatic step(input bp_fetch_t f, input bp_resolve_t r, input logic en,
                      input logic st, input logic fl);
    @(posedge clk);
    advance_model();
    fetch   <= f;
    resolve <= r;
    enable  <= en;
    stall   <= st;
    flush   <= fl;
    @(negedge clk);
    check_predict(predict, lookup_ref(fetch.pc, enable));
    check_if_id(if_id, exp_if_id);
  endtask

  // Fetch the branch, let it reach IF/ID, then resolve it with its carried state.
  task automatic resolve_branch(input logic [PC_WIDTH_DEF-1:0] pc, input logic taken,
                                input bp_target_t tgt, input logic wen_bht, input logic wen_btb);
    step(fetch_of(pc, 1'b1), '0, 1'b1, 1'b0, 1'b0);
    step(fetch_of(16'h0000, 1'b0), '0, 1'b1, 1'b0, 1'b0);   // Bubble.
    step(fetch_of(16'h0000, 1'b0),
         resolve_of(pc, if_id.pred.state, taken, tgt, wen_bht, wen_btb), 1'b1, 1'b0, 1'b0);
  endtask

  task automatic apply_reset();
    repeat (2) begin
      @(posedge clk);
      advance_model();
    end
    rst <= 1'b0;                                     // Released after two edges.
    @(negedge clk);
    if (if_id.valid !== 1'b0) report_value("if_id.valid", 32'(if_id.valid), 32'd0);
    check_if_id(if_id, exp_if_id);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic reset_and_miss();
    logic [31:0] r;
    repeat (8) begin
      r = $random(seed);
      step(fetch_of(r[15:0], 1'b1), '0, 1'b1, 1'b0, 1'b0);
      check_predict(predict, pred_value(weak_not_taken, 1'b0, 16'h0000));
    end
  endtask

  task automatic counter_training();
    logic      outcome [6];
    bp_state_t expect_state [6];
    outcome      = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0};
    expect_state = '{weak_taken, strong_taken, strong_taken, strong_taken,
                     weak_taken, weak_not_taken};
    for (int k = 0; k < 6; k++) begin
      resolve_branch(16'h1234, outcome[k], 16'h0000, 1'b1, 1'b0);
      step(fetch_of(16'h1234, 1'b1), '0, 1'b1, 1'b0, 1'b0);
      if (predict.state !== expect_state[k]) begin
        report_value("predict.state", 32'(predict.state), 32'(expect_state[k]));
      end
    end
  endtask

  task automatic target_buffer();
    int n;
    n = 0;
    resolve_branch(16'h2468, 1'b1, 16'h3a5c, 1'b0, 1'b1);   // Target only.
    step(fetch_of(16'h2468, 1'b1), '0, 1'b1, 1'b0, 1'b0);
    check_predict(predict, pred_value(weak_not_taken, 1'b0, 16'h3a5c));
    while (!predict.taken) begin
      if (n == TRAIN_LIMIT) timeout_stop("counter never reached a taken state");
      resolve_branch(16'h2468, 1'b1, 16'h0000, 1'b1, 1'b0);
      step(fetch_of(16'h2468, 1'b1), '0, 1'b1, 1'b0, 1'b0);
      n++;
    end
    check_predict(predict, pred_value(weak_taken, 1'b1, 16'h3a5c));
  endtask

  task automatic aliasing();
    resolve_branch(16'h0106, 1'b1, 16'h0000, 1'b1, 1'b0);   // Same index 3 as 16'h0906.
    resolve_branch(16'h0106, 1'b1, 16'h0000, 1'b1, 1'b0);
    step(fetch_of(16'h0106, 1'b1), '0, 1'b1, 1'b0, 1'b0);
    step(fetch_of(16'h0000, 1'b0), '0, 1'b1, 1'b0, 1'b0);
    check_predict(if_id.pred, pred_value(strong_taken, 1'b1, 16'h0000));
    step(fetch_of(16'h0000, 1'b0),
         resolve_of(16'h0906, if_id.pred.state, 1'b1, 16'h0000, 1'b1, 1'b0),
         1'b1, 1'b0, 1'b0);
    step(fetch_of(16'h0906, 1'b1), '0, 1'b1, 1'b0, 1'b0);
    check_predict(predict, pred_value(weak_not_taken, 1'b0, 16'h0000));
    step(fetch_of(16'h0106, 1'b1), '0, 1'b1, 1'b0, 1'b0);   // Now a miss.
    check_predict(predict, pred_value(weak_not_taken, 1'b0, 16'h0000));
  endtask

  task automatic enable_gating();
    repeat (3) begin
      step(fetch_of(16'h2468, 1'b1),
           resolve_of(16'h2468, weak_taken, 1'b0, 16'hdead, 1'b1, 1'b1), 1'b0, 1'b0, 1'b0);
      check_predict(predict, pred_value(weak_not_taken, 1'b0, 16'h0000));
    end
    step(fetch_of(16'h2468, 1'b1), '0, 1'b1, 1'b0, 1'b0);
    check_predict(predict, pred_value(weak_taken, 1'b1, 16'h3a5c));
    step(fetch_of(16'h1234, 1'b1), '0, 1'b1, 1'b0, 1'b0);
    check_predict(predict, pred_value(weak_not_taken, 1'b0, 16'h0000));
  endtask

  task automatic pipeline_random();
    logic [31:0] r;
    logic [31:0] r2;
    bp_resolve_t res;
    for (int k = 0; k < 48; k++) begin
      r   = $random(seed);
      r2  = $random(seed);
      res = resolve_of(r2[15:0], bp_state_t'(r2[17:16]), r2[18], {r[31:24], r2[31:24]},
                       r2[19], r2[20]);
      step(fetch_of(r[15:0], r[16]), res, |r2[23:21], r[17] & r[18], r[19] & r[20] & r[21]);
    end
  endtask

  initial begin
    seed        = 32'hf1c0c915;
    error_count = 0;
    rst         = 1'b1;
    enable      = 1'b0;
    stall       = 1'b0;
    flush       = 1'b0;
    fetch       = '0;
    resolve     = '0;
    exp_if_id   = '0;
    apply_reset();
    reset_and_miss();
    counter_training();
    target_buffer();
    aliasing();
    enable_gating();
    pipeline_random();
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
common/bp_pkg.sv
hw/predictor/bp_tag_table.sv
hw/predictor/bp_counter_update.sv
hw/predictor/branch_predictor.sv
hw/bp_if_id_reg.sv
hw/bp_top.sv
dv/bp_props.sv
dv/bp_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the branch predictor testbench with Verilator, run it and scan the log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module bp_tb -f verilog.f -o bp_sim \
  > sim.log 2>&1 && ./obj_dir/bp_sim >> sim.log 2>&1 || echo "Build or run stopped early"
if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"
exit 0
